// File: hw/regread_pkg.sv
`default_nettype none

package regread_pkg;

    // ------------------------------------------------------------------------
    // Datapath and register file sizes
    // ------------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int PREG_WIDTH = 6;
    localparam int PREG_SIZE  = 64;          // One entry per physical register number

    // ------------------------------------------------------------------------
    // Requester and port counts
    // ------------------------------------------------------------------------
    localparam int ALU_SIZE   = 2;
    localparam int LOAD_SIZE  = 1;
    localparam int WB_SIZE    = 2;

    // Two sources per ALU lane, then one per load port
    localparam int READ_PORTS = ALU_SIZE * 2 + LOAD_SIZE;
    localparam int LOAD_BASE  = ALU_SIZE * 2;  // First read port owned by the load group

    // ------------------------------------------------------------------------
    // Common types
    // ------------------------------------------------------------------------
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [PREG_WIDTH-1:0] preg_t;

endpackage

`default_nettype wire

// File: hw/issue_reg_if.sv
`timescale 1ns/100ps
`default_nettype none

// Source s of lane l sits at index s*LANES + l in preg and data
interface issue_reg_if import regread_pkg::*; #(
    parameter int LANES = 1,
    parameter int SRCS  = 2
);

    logic  [LANES-1:0]           en;
    preg_t [LANES*SRCS-1:0]      preg;
    logic  [LANES-1:0]           ready;
    word_t [LANES*SRCS-1:0]      data;

    // Issue queue side
    modport requester (
        output en,
        output preg,
        input  ready,
        input  data
    );

    // Register read stage side
    modport regfile (
        input  en,
        input  preg,
        output ready,
        output data
    );

endinterface

`default_nettype wire

// File: hw/wb_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface wb_bus_if import regread_pkg::*;;

    logic  [WB_SIZE-1:0] en;
    logic  [WB_SIZE-1:0] we;    // A port only writes when en and we are both set
    preg_t [WB_SIZE-1:0] rd;
    word_t [WB_SIZE-1:0] res;

    modport source (
        output en,
        output we,
        output rd,
        output res
    );

    // Register file and bypass network both watch the same writebacks
    modport sink (
        input  en,
        input  we,
        input  rd,
        input  res
    );

endinterface

`default_nettype wire

// File: hw/read_port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module read_port_arbiter import regread_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  word_t [READ_PORTS-1:0] read_data,
    issue_reg_if.regfile           alu_io,
    issue_reg_if.regfile           csr_io,
    issue_reg_if.regfile           load_io,
    output preg_t [READ_PORTS-1:0] raddr
);

    preg_t [READ_PORTS-1:0] raddr_nxt;
    logic  [READ_PORTS-1:0] raddr_ld;

    // ------------------------------------------------------------------------
    // Port selection
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < ALU_SIZE; i++) begin
            raddr_nxt[i]          = alu_io.preg[i];
            raddr_nxt[ALU_SIZE+i] = alu_io.preg[ALU_SIZE+i];
            raddr_ld[i]           = alu_io.en[i];
            raddr_ld[ALU_SIZE+i]  = alu_io.en[i];
        end

        // CSR borrows both read ports of ALU lane 0
        if (csr_io.en[0]) begin
            raddr_nxt[0]        = csr_io.preg[0];
            raddr_nxt[ALU_SIZE] = csr_io.preg[1];
            raddr_ld[0]         = 1'b1;
            raddr_ld[ALU_SIZE]  = 1'b1;
        end

        for (int i = 0; i < LOAD_SIZE; i++) begin
            raddr_nxt[LOAD_BASE+i] = load_io.preg[i];
            raddr_ld[LOAD_BASE+i]  = load_io.en[i];
        end
    end

    // Idle ports keep their last address so the file inputs stay quiet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raddr <= '0;
        end else begin
            for (int p = 0; p < READ_PORTS; p++) begin
                if (raddr_ld[p]) begin
                    raddr[p] <= raddr_nxt[p];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Ready flags
    // ------------------------------------------------------------------------
    always_comb begin
        alu_io.ready    = '1;
        alu_io.ready[0] = ~csr_io.en[0];    // Lane 0 stalls while the CSR holds its ports
    end

    assign csr_io.ready  = 1'b1;
    assign load_io.ready = '1;

    // ------------------------------------------------------------------------
    // Return data
    // ------------------------------------------------------------------------
    assign alu_io.data     = read_data[ALU_SIZE*2-1:0];
    assign csr_io.data[0]  = read_data[0];
    assign csr_io.data[1]  = read_data[ALU_SIZE];   // Second source of lane 0
    assign load_io.data    = read_data[LOAD_BASE +: LOAD_SIZE];

endmodule

`default_nettype wire

// File: hw/phys_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module phys_regfile import regread_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    wb_bus_if.sink                 wb,
    input  preg_t [READ_PORTS-1:0] raddr,
    output word_t [READ_PORTS-1:0] rdata
);

    word_t              regs [PREG_SIZE];
    logic [WB_SIZE-1:0] wr_en;

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < WB_SIZE; w++) begin
            // Writebacks are ignored while the core is held in reset
            wr_en[w] = rst_n & wb.en[w] & wb.we[w] & (wb.rd[w] != '0);
        end
    end

    // Later ports overwrite earlier ones on the same register
    always_ff @(posedge clk) begin
        for (int w = 0; w < WB_SIZE; w++) begin
            if (wr_en[w]) begin
                regs[wb.rd[w]] <= wb.res[w];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    generate
        for (genvar p = 0; p < READ_PORTS; p++) begin : g_read
            // Entry 0 is never written, so force the zero here
            assign rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/bypass_net.sv
`timescale 1ns/100ps
`default_nettype none

module bypass_net import regread_pkg::*; (
    input  preg_t [READ_PORTS-1:0] raddr,
    input  word_t [READ_PORTS-1:0] reg_rdata,
    wb_bus_if.sink                 wb,
    output word_t [READ_PORTS-1:0] rdata
);

    logic [WB_SIZE-1:0] wb_valid;

    // A writeback that will land at the coming edge and can be forwarded
    always_comb begin
        for (int w = 0; w < WB_SIZE; w++) begin
            wb_valid[w] = wb.en[w] & wb.we[w] & (wb.rd[w] != '0);
        end
    end

    // ------------------------------------------------------------------------
    // Forwarding mux
    // ------------------------------------------------------------------------
    always_comb begin
        rdata = reg_rdata;
        for (int p = 0; p < READ_PORTS; p++) begin
            for (int w = 0; w < WB_SIZE; w++) begin
                if (wb_valid[w] && (wb.rd[w] == raddr[p])) begin
                    rdata[p] = wb.res[w];   // Higher writeback port wins, as in the file
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/regread_top.sv
`timescale 1ns/100ps
`default_nettype none

module regread_top import regread_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // ALU lanes
    input  logic  [ALU_SIZE-1:0]   alu_en,
    input  preg_t [ALU_SIZE*2-1:0] alu_preg,
    output logic  [ALU_SIZE-1:0]   alu_ready,
    output word_t [ALU_SIZE*2-1:0] alu_data,

    // CSR requester
    input  logic                   csr_en,
    input  preg_t [1:0]            csr_preg,
    output word_t [1:0]            csr_data,

    // Load ports
    input  logic  [LOAD_SIZE-1:0]  load_en,
    input  preg_t [LOAD_SIZE-1:0]  load_preg,
    output word_t [LOAD_SIZE-1:0]  load_data,

    // Writeback ports
    input  logic  [WB_SIZE-1:0]    wb_en,
    input  logic  [WB_SIZE-1:0]    wb_we,
    input  preg_t [WB_SIZE-1:0]    wb_rd,
    input  word_t [WB_SIZE-1:0]    wb_res
);

    preg_t [READ_PORTS-1:0] raddr;
    word_t [READ_PORTS-1:0] reg_rdata;      // Raw file output
    word_t [READ_PORTS-1:0] byp_rdata;      // After forwarding

    // ------------------------------------------------------------------------
    // Requester bundles
    // ------------------------------------------------------------------------
    issue_reg_if #(.LANES(ALU_SIZE),  .SRCS(2)) alu_io ();
    issue_reg_if #(.LANES(1),         .SRCS(2)) csr_io ();
    issue_reg_if #(.LANES(LOAD_SIZE), .SRCS(1)) load_io ();
    wb_bus_if                                   wb_bus ();

    assign alu_io.en    = alu_en;
    assign alu_io.preg  = alu_preg;
    assign alu_ready    = alu_io.ready;
    assign alu_data     = alu_io.data;

    assign csr_io.en    = csr_en;
    assign csr_io.preg  = csr_preg;
    assign csr_data     = csr_io.data;   // CSR and load are never back-pressured

    assign load_io.en   = load_en;
    assign load_io.preg = load_preg;
    assign load_data    = load_io.data;

    assign wb_bus.en    = wb_en;
    assign wb_bus.we    = wb_we;
    assign wb_bus.rd    = wb_rd;
    assign wb_bus.res   = wb_res;

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    read_port_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .read_data (byp_rdata),
        .alu_io    (alu_io),
        .csr_io    (csr_io),
        .load_io   (load_io),
        .raddr     (raddr)
    );

    phys_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb        (wb_bus),
        .raddr     (raddr),
        .rdata     (reg_rdata)
    );

    // Same-cycle writebacks override the file output
    bypass_net u_bypass (
        .raddr     (raddr),
        .reg_rdata (reg_rdata),
        .wb        (wb_bus),
        .rdata     (byp_rdata)
    );

endmodule

`default_nettype wire

// File: dv/regread_tb.sv
`timescale 1ns/100ps
`default_nettype none

module regread_tb import regread_pkg::*;;

    localparam int CLK_PERIOD    = 100;
    localparam int WAIT_LIMIT    = 20;
    localparam int RANDOM_CYCLES = 400;

    logic                   clk;
    logic                   rst_n;
    logic  [ALU_SIZE-1:0]   alu_en,    stim_alu_en;
    preg_t [ALU_SIZE*2-1:0] alu_preg,  stim_alu_preg;
    logic  [ALU_SIZE-1:0]   alu_ready;
    word_t [ALU_SIZE*2-1:0] alu_data;
    logic                   csr_en,    stim_csr_en;
    preg_t [1:0]            csr_preg,  stim_csr_preg;
    word_t [1:0]            csr_data;
    logic  [LOAD_SIZE-1:0]  load_en,   stim_load_en;
    preg_t [LOAD_SIZE-1:0]  load_preg, stim_load_preg;
    word_t [LOAD_SIZE-1:0]  load_data;
    logic  [WB_SIZE-1:0]    wb_en,     stim_wb_en;
    logic  [WB_SIZE-1:0]    wb_we,     stim_wb_we;
    preg_t [WB_SIZE-1:0]    wb_rd,     stim_wb_rd;
    word_t [WB_SIZE-1:0]    wb_res,    stim_wb_res;

    word_t                  model [PREG_SIZE];     // Mirror of the physical file
    logic  [ALU_SIZE-1:0]   pend_alu;              // Requests accepted last cycle
    preg_t [ALU_SIZE*2-1:0] pend_alu_preg;
    logic                   pend_csr;
    preg_t [1:0]            pend_csr_preg;
    logic  [LOAD_SIZE-1:0]  pend_load;
    preg_t [LOAD_SIZE-1:0]  pend_load_preg;
    logic                   lane0_taken;
    logic  [31:0]           lfsr_state;
    int                     errors;
    int                     checks;
    int                     timeouts;
    int                     wait_cnt;
    preg_t                  r;

    regread_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_en    (alu_en),
        .alu_preg  (alu_preg),
        .alu_ready (alu_ready),
        .alu_data  (alu_data),
        .csr_en    (csr_en),
        .csr_preg  (csr_preg),
        .csr_data  (csr_data),
        .load_en   (load_en),
        .load_preg (load_preg),
        .load_data (load_data),
        .wb_en     (wb_en),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd),
        .wb_res    (wb_res)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * 5000);
        $display("Simulation did not finish within its time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Random source from a 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
    // ------------------------------------------------------------------------
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic preg_t rand_preg();
        preg_t v;
        for (int i = 0; i < PREG_WIDTH; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    function automatic preg_t rand_nonzero_preg();
        preg_t v;
        v = rand_preg();
        if (v == '0) v = preg_t'(1);
        return v;
    endfunction

    function automatic word_t rand_word();
        word_t v;
        for (int i = 0; i < XLEN; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Cycle driver and checker
    // ------------------------------------------------------------------------
    task automatic check_word(input string what, input int idx, input word_t got,
                              input preg_t rd);
        checks++;
        assert (got === model[rd]) else begin
            $display("FAIL @ %0t: %s[%0d] reading p%0d returned %h, expected %h",
                     $time, what, idx, rd, got, model[rd]);
            errors++;
        end
    endtask

    task automatic idle_stim();
        stim_alu_en  = '0;
        stim_csr_en  = 1'b0;
        stim_load_en = '0;
        stim_wb_en   = '0;
        stim_wb_we   = '0;
    endtask

    task automatic clock_cycle();
        @(negedge clk);
        alu_en    = stim_alu_en;
        alu_preg  = stim_alu_preg;
        csr_en    = stim_csr_en;
        csr_preg  = stim_csr_preg;
        load_en   = stim_load_en;
        load_preg = stim_load_preg;
        wb_en     = stim_wb_en;
        wb_we     = stim_wb_we;
        wb_rd     = stim_wb_rd;
        wb_res    = stim_wb_res;
        #(CLK_PERIOD/4);
        checks++;
        assert (alu_ready[0] == !csr_en && alu_ready[ALU_SIZE-1:1] == '1) else begin
            $display("FAIL @ %0t: alu_ready is %b with csr_en %b", $time, alu_ready, csr_en);
            errors++;
        end
        // Writebacks of this cycle land at the next edge and are already forwarded
        for (int w = 0; w < WB_SIZE; w++) begin
            if (wb_en[w] && wb_we[w] && wb_rd[w] != '0) model[wb_rd[w]] = wb_res[w];
        end
        for (int l = 0; l < ALU_SIZE; l++) begin
            if (pend_alu[l]) begin
                check_word("alu_data", l, alu_data[l], pend_alu_preg[l]);
                check_word("alu_data", ALU_SIZE+l, alu_data[ALU_SIZE+l],
                           pend_alu_preg[ALU_SIZE+l]);
            end
        end
        if (pend_csr) begin
            check_word("csr_data", 0, csr_data[0], pend_csr_preg[0]);
            check_word("csr_data", 1, csr_data[1], pend_csr_preg[1]);
        end
        for (int l = 0; l < LOAD_SIZE; l++) begin
            if (pend_load[l]) check_word("load_data", l, load_data[l], pend_load_preg[l]);
        end
        pend_alu       = alu_en & alu_ready;
        pend_alu_preg  = alu_preg;
        pend_csr       = csr_en;
        pend_csr_preg  = csr_preg;
        pend_load      = load_en;
        pend_load_preg = load_preg;
        lane0_taken    = pend_alu[0];
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        lfsr_state = 32'd69975;
        errors = 0;
        checks = 0;
        timeouts = 0;
        rst_n = 1'b0;
        {alu_en, alu_preg, csr_en, csr_preg, load_en, load_preg} = '0;
        {wb_en, wb_we, wb_rd, wb_res} = '0;
        {stim_alu_preg, stim_csr_preg, stim_load_preg, stim_wb_rd, stim_wb_res} = '0;
        {pend_alu, pend_csr, pend_load, lane0_taken} = '0;
        for (int i = 0; i < PREG_SIZE; i++) model[i] = '0;
        idle_stim();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Addresses come out of reset at 0, so every output reads zero
        clock_cycle();
        for (int p = 0; p < ALU_SIZE*2; p++) check_word("alu_data", p, alu_data[p], '0);
        check_word("csr_data", 0, csr_data[0], '0);
        check_word("load_data", 0, load_data[0], '0);

        // Fill the whole file, pairs of registers per cycle
        for (int i = 1; i < PREG_SIZE; i += 2) begin
            stim_wb_en = '1;
            stim_wb_we = '1;
            stim_wb_rd[0] = preg_t'(i);
            stim_wb_rd[1] = preg_t'(i + 1);   // 64 wraps onto register 0
            stim_wb_res[0] = rand_word();
            stim_wb_res[1] = rand_word();
            clock_cycle();
        end
        idle_stim();

        // Basic reads on both ALU lanes and the load port
        for (int i = 0; i < 20; i++) begin
            stim_alu_en  = '1;
            stim_load_en = '1;
            for (int p = 0; p < ALU_SIZE*2; p++) stim_alu_preg[p] = rand_preg();
            stim_load_preg[0] = rand_preg();
            clock_cycle();
        end

        // Register 0 ignores a write and reads zero, also through the bypass
        stim_alu_preg = '0;
        stim_load_preg = '0;
        stim_wb_en = '0;
        clock_cycle();
        stim_wb_en = 2'b01;
        stim_wb_we = 2'b01;
        stim_wb_rd[0] = '0;
        stim_wb_res[0] = rand_word();
        clock_cycle();
        stim_wb_en = '0;
        clock_cycle();

        // A writeback with we low is not a write, neither in the file nor forwarded
        r = rand_nonzero_preg();
        stim_alu_preg = {ALU_SIZE*2{r}};
        stim_load_preg[0] = r;
        stim_wb_en = 2'b10;
        stim_wb_we = 2'b00;
        stim_wb_rd[1] = r;
        stim_wb_res[1] = ~model[r];
        clock_cycle();
        clock_cycle();
        stim_wb_en = '0;
        clock_cycle();

        // Read a register, then write it while its data is presented
        for (int i = 0; i < 16; i++) begin
            r = rand_nonzero_preg();
            stim_alu_preg = {ALU_SIZE*2{r}};
            stim_load_preg[0] = r;
            stim_wb_en = '0;
            clock_cycle();
            stim_wb_en = lfsr_bit() ? 2'b10 : 2'b01;
            stim_wb_we = '1;
            stim_wb_rd = {WB_SIZE{r}};
            stim_wb_res = {rand_word(), rand_word()};
            clock_cycle();
        end
        idle_stim();
        clock_cycle();

        // CSR borrows lane 0, lane 1 keeps going and lane 0 retries
        stim_alu_en = '1;
        stim_csr_en = 1'b1;
        for (int p = 0; p < ALU_SIZE*2; p++) stim_alu_preg[p] = rand_preg();
        for (int i = 0; i < 3; i++) begin
            stim_csr_preg = {rand_preg(), rand_preg()};
            stim_alu_preg[1] = rand_preg();
            clock_cycle();
        end
        stim_csr_en = 1'b0;
        wait_cnt = 0;
        lane0_taken = 1'b0;
        while (!lane0_taken && wait_cnt < WAIT_LIMIT) begin
            clock_cycle();
            wait_cnt++;
        end
        if (!lane0_taken) begin
            $display("Timeout: ALU lane 0 request was never accepted after the CSR read");
            timeouts++;
        end

        // Random traffic on every requester and both writeback ports
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            if (!(alu_en[0] && !lane0_taken)) begin   // A refused lane 0 request is held
                stim_alu_en[0] = lfsr_bit();
                stim_alu_preg[0] = rand_preg();
                stim_alu_preg[ALU_SIZE] = rand_preg();
            end
            stim_alu_en[1] = lfsr_bit();
            stim_alu_preg[1] = rand_preg();
            stim_alu_preg[ALU_SIZE+1] = rand_preg();
            stim_csr_en = lfsr_bit() & lfsr_bit();
            stim_csr_preg = {rand_preg(), rand_preg()};
            stim_load_en[0] = lfsr_bit();
            stim_load_preg[0] = rand_preg();
            for (int w = 0; w < WB_SIZE; w++) begin
                stim_wb_en[w] = lfsr_bit();
                stim_wb_we[w] = lfsr_bit() | lfsr_bit();
                stim_wb_rd[w] = rand_preg();
                stim_wb_res[w] = rand_word();
            end
            if (stim_wb_rd[1] == stim_wb_rd[0]) stim_wb_rd[1] = stim_wb_rd[0] + preg_t'(1);
            clock_cycle();
        end
        idle_stim();
        clock_cycle();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/regread_pkg.sv
hw/issue_reg_if.sv
hw/wb_bus_if.sv
hw/read_port_arbiter.sv
hw/phys_regfile.sv
hw/bypass_net.sv
hw/regread_top.sv
dv/regread_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = regread_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
